/* vlog.f */
verilog/fetch_pkg.sv
verilog/inst_queue.sv
verilog/branch_predictor.sv
verilog/predecode.sv
verilog/fetch_stage.sv
verilog/fetch_unit.sv
test/clock_gen.sv
test/imem_model.sv
test/fetch_unit_tb.sv

/* Bender.yml */
package:
  name: fetch_unit

sources:
  - files:
      - verilog/fetch_pkg.sv
      - verilog/inst_queue.sv
      - verilog/branch_predictor.sv
      - verilog/predecode.sv
      - verilog/fetch_stage.sv
      - verilog/fetch_unit.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/imem_model.sv
      - test/fetch_unit_tb.sv

/* test/fetch_unit_tb.sv */
`timescale 1ns/100ps

module fetch_unit_tb;
    import fetch_pkg::*;

    localparam addr_t reset_pc = '0;
    localparam addr_t err_lo   = 32'h0000_2000;
    localparam addr_t err_hi   = 32'h0000_2008;

    logic         clk;
    logic         rst_n;
    redirect_t    redirect;
    br_update_t   brinfo;
    mem_req_t     memreq;
    logic         memreq_ready;
    mem_resp_t    memresp;
    fetch_out_t   iresp;
    logic         iresp_ready;

    // shadow of the predictor counters
    logic [1:0]   ctr [64];
    addr_t        exp_addr;
    fetch_entry_t last;
    int           consumed;
    int           errors;
    int           tests;
    int           failed;
    logic         in_flight;

    clock_gen clk0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    imem_model #(
        .err_lo (err_lo),
        .err_hi (err_hi)
    ) imem0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .memreq       (memreq),
        .memreq_ready (memreq_ready),
        .memresp      (memresp)
    );

    fetch_unit dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect     (redirect),
        .brinfo       (brinfo),
        .memreq       (memreq),
        .memreq_ready (memreq_ready),
        .memresp      (memresp),
        .iresp        (iresp),
        .iresp_ready  (iresp_ready)
    );

    // one fetch in flight at a time
    always @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else begin
            if (in_flight && memreq.valid && !memresp.valid) begin
                $display("memreq.valid was high while a fetch was still outstanding");
                errors++;
            end
            in_flight <= (memreq.valid && memreq_ready) || (in_flight && !memresp.valid);
        end
    end

    function automatic addr_t b_offset(inst_t w);
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    // jal, then predicted branch, then the next word
    function automatic addr_t next_addr(addr_t pc, inst_t w, logic err);
        addr_t j_off;
        j_off = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        if (err) return pc + 4;
        if (w[6:0] == op_jal) return pc + j_off;
        if (w[6:0] == op_branch && ctr[pc[7:2]][1]) return pc + b_offset(w);
        return pc + 4;
    endfunction

    task automatic check_entry(input fetch_entry_t e);
        logic  in_err;
        inst_t w;
        in_err = (e.addr >= err_lo) && (e.addr < err_hi);
        w = in_err ? inst_nop : imem0.word_at(e.addr);
        if (e.addr !== exp_addr) begin
            $display("Fail iresp.addr: got %h, expected %h", e.addr, exp_addr);
            errors++;
        end
        if (e.inst !== w) begin
            $display("Fail iresp.inst: got %h, expected %h", e.inst, w);
            errors++;
        end
        if (e.error !== in_err) begin
            $display("Fail iresp.error: got %h, expected %h", e.error, in_err);
            errors++;
        end
        exp_addr = next_addr(e.addr, w, in_err);
        last = e;
        consumed++;
    endtask

    task automatic drive_cycle(input logic rdy, input redirect_t rd, input br_update_t bu);
        int idx;
        @(negedge clk);
        iresp_ready = rdy;
        redirect    = rd;
        brinfo      = bu;
        idx = bu.pc[7:2];
        if (iresp.valid && rdy) check_entry(iresp.entry);
        if (bu.valid && bu.taken && ctr[idx] != 2'b11) begin
            ctr[idx] = ctr[idx] + 2'b01;
        end
        if (bu.valid && !bu.taken && ctr[idx] != 2'b00) begin
            ctr[idx] = ctr[idx] - 2'b01;
        end
        if (rd.valid) exp_addr = rd.addr;
    endtask

    task automatic redirect_to(input addr_t a);
        redirect_t rd;
        rd.valid = 1'b1;
        rd.addr  = a;
        drive_cycle(1'b0, rd, '0);
    endtask

    task automatic train(input addr_t pc, input logic taken, input int times);
        br_update_t bu;
        bu.valid = 1'b1;
        bu.pc    = pc;
        bu.taken = taken;
        repeat (times) drive_cycle(1'b0, '0, bu);
    endtask

    // mode 0 always ready, 1 mostly ready, 2 long stalls
    task automatic run_entries(input int n, input int mode);
        int   target;
        int   cycles;
        int   stretch;
        logic rdy;
        target  = consumed + n;
        cycles  = 0;
        stretch = 0;
        rdy     = 1'b1;
        while (consumed < target && cycles < 50 * n + 100) begin
            if (mode == 2) begin
                if (stretch == 0) begin
                    rdy = ~rdy;
                    stretch = rdy ? 1 + $urandom % 8 : 10 + $urandom % 40;
                end
                stretch--;
            end else begin
                rdy = (mode == 0) || ($urandom % 4) != 0;
            end
            drive_cycle(rdy, '0, '0);
            cycles++;
        end
        if (consumed < target) begin
            $display("timed out, only %0d of %0d entries arrived", n - target + consumed, n);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        if (errors != err0) begin
            failed++;
            $display("test %0d %s: failed", tests, name);
        end else begin
            $display("test %0d %s: ok", tests, name);
        end
    endtask

    initial begin
        int    err0;
        int    n;
        addr_t br_pc;
        inst_t w;
        void'($urandom(95));
        iresp_ready = 1'b0;
        redirect    = '0;
        brinfo      = '0;
        for (int i = 0; i < 64; i++) begin
            ctr[i] = 2'b01;
        end
        exp_addr = reset_pc;
        consumed = 0;
        errors   = 0;
        tests    = 0;
        failed   = 0;

        err0 = errors;
        n = 0;
        while (rst_n !== 1'b1 && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            errors++;
        end
        run_entries(20, 0);
        end_test("reset fetch", err0);

        err0 = errors;
        run_entries(300, 1);
        end_test("flow order", err0);

        err0 = errors;
        n = 0;
        br_pc = 32'h0000_1000;
        w = imem0.word_at(br_pc);
        while (n < 1024 && !(w[6:0] == op_branch && b_offset(w) != 32'd4)) begin
            br_pc = br_pc + 4;
            w = imem0.word_at(br_pc);
            n++;
        end
        if (n == 1024) begin
            $display("no branch found in the memory image");
            errors++;
        end
        train(br_pc, 1'b1, 2);
        redirect_to(br_pc);
        run_entries(2, 0);
        if (last.addr !== br_pc + b_offset(w)) begin
            $display("Fail iresp.addr: got %h, expected %h", last.addr, br_pc + b_offset(w));
            errors++;
        end
        train(br_pc, 1'b0, 3);
        redirect_to(br_pc);
        run_entries(2, 0);
        if (last.addr !== br_pc + 4) begin
            $display("Fail iresp.addr: got %h, expected %h", last.addr, br_pc + 4);
            errors++;
        end
        end_test("branch training", err0);

        err0 = errors;
        repeat (20) begin
            repeat ($urandom % 30) drive_cycle(($urandom % 4) != 0, '0, '0);
            redirect_to(addr_t'(($urandom % 1024) * 4));
            run_entries(3, 1);
        end
        end_test("redirects", err0);

        err0 = errors;
        redirect_to(err_lo);
        run_entries(1, 0);
        if (last.inst !== inst_nop) begin
            $display("Fail iresp.inst: got %h, expected %h", last.inst, inst_nop);
            errors++;
        end
        if (last.error !== 1'b1) begin
            $display("Fail iresp.error: got %h, expected %h", last.error, 1'b1);
            errors++;
        end
        run_entries(1, 0);
        if (last.addr !== err_lo + 4) begin
            $display("Fail iresp.addr: got %h, expected %h", last.addr, err_lo + 4);
            errors++;
        end
        end_test("fetch error", err0);

        err0 = errors;
        run_entries(200, 2);
        end_test("back-pressure", err0);

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* test/imem_model.sv */
`timescale 1ns/100ps

module imem_model #(
    parameter fetch_pkg::addr_t err_lo = 32'h0000_2000,
    parameter fetch_pkg::addr_t err_hi = 32'h0000_2008
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_pkg::mem_req_t   memreq,
    output logic                  memreq_ready,
    output fetch_pkg::mem_resp_t  memresp
);
    import fetch_pkg::*;

    logic  accepted;
    addr_t accepted_addr;
    logic  busy;
    addr_t addr;
    int    left;

    // hashed contents with mostly plain words and some jal and branch
    function automatic inst_t word_at(addr_t a);
        logic [31:0] h;
        logic [31:0] off;
        h   = (a ^ (a >> 13)) * 32'h2545_f491;
        h   = h ^ (h >> 16);
        // word aligned offset from -64 to +188 bytes
        off = {24'h0, h[11:6], 2'b00} - 32'd64;
        case (h[2:0])
            3'd0: begin
                return {off[20], off[10:1], off[11], off[19:12], h[16:12], op_jal};
            end
            3'd1, 3'd2: begin
                return {off[12], off[10:5], h[24:20], h[19:15], h[14:12],
                        off[4:1], off[11], op_branch};
            end
            default: begin
                return {h[31:20], h[19:15], 3'b000, h[11:7], 7'b001_0011};
            end
        endcase
    endfunction

    initial begin
        memresp      = '0;
        memreq_ready = 1'b0;
        busy         = 1'b0;
        accepted     = 1'b0;
    end

    always @(posedge clk) begin
        accepted      <= rst_n && memreq.valid && memreq_ready;
        accepted_addr <= memreq.addr;
    end

    // one request at a time answered 1 to 4 cycles after acceptance
    always @(negedge clk) begin
        memresp.valid = 1'b0;
        memreq_ready  = ($urandom % 4) != 0;
        if (!rst_n) begin
            busy = 1'b0;
        end else if (accepted) begin
            busy = 1'b1;
            addr = accepted_addr;
            left = $urandom % 4;
        end
        if (busy && left == 0) begin
            busy          = 1'b0;
            memresp.valid = 1'b1;
            memresp.error = (addr >= err_lo) && (addr < err_hi);
            memresp.data  = word_at(addr);
        end else if (busy) begin
            left--;
        end
    end

endmodule

/* test/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // low over the first 8 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit #(
    parameter fetch_pkg::addr_t reset_pc = '0,
    parameter int queue_depth = 8,
    parameter int bp_index_bits = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::redirect_t    redirect,
    input  fetch_pkg::br_update_t   brinfo,
    output fetch_pkg::mem_req_t     memreq,
    input  logic                    memreq_ready,
    input  fetch_pkg::mem_resp_t    memresp,
    output fetch_pkg::fetch_out_t   iresp,
    input  logic                    iresp_ready
);
    import fetch_pkg::*;

    logic                         q_wvalid;
    logic                         q_kill;
    fetch_entry_t                 q_wdata;
    logic [$clog2(queue_depth):0] free_slots;

    addr_t request_pc;
    addr_t jal_target;
    addr_t br_target;
    logic  is_jal;
    logic  is_branch;
    logic  pred_taken;

    fetch_stage #(
        .reset_pc    (reset_pc),
        .queue_depth (queue_depth)
    ) stage0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect     (redirect),
        .memreq       (memreq),
        .memreq_ready (memreq_ready),
        .memresp      (memresp),
        .free_slots   (free_slots),
        .q_wvalid     (q_wvalid),
        .q_wdata      (q_wdata),
        .q_kill       (q_kill),
        .request_pc   (request_pc),
        .is_jal       (is_jal),
        .is_branch    (is_branch),
        .pred_taken   (pred_taken),
        .jal_target   (jal_target),
        .br_target    (br_target)
    );

    inst_queue #(
        .depth (queue_depth)
    ) queue0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .kill        (q_kill),
        .wvalid      (q_wvalid),
        .wdata       (q_wdata),
        .free_slots  (free_slots),
        .iresp       (iresp),
        .iresp_ready (iresp_ready)
    );

    predecode pdec0 (
        .inst       (memresp.data),
        .pc         (request_pc),
        .error      (memresp.error),
        .is_jal     (is_jal),
        .is_branch  (is_branch),
        .jal_target (jal_target),
        .br_target  (br_target)
    );

    branch_predictor #(
        .index_bits (bp_index_bits)
    ) bp0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (request_pc),
        .pred_taken (pred_taken),
        .brinfo     (brinfo)
    );

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage #(
    parameter fetch_pkg::addr_t reset_pc = '0,
    parameter int queue_depth = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  fetch_pkg::redirect_t            redirect,
    output fetch_pkg::mem_req_t             memreq,
    input  logic                            memreq_ready,
    input  fetch_pkg::mem_resp_t            memresp,
    input  logic [$clog2(queue_depth):0]    free_slots,
    output logic                            q_wvalid,
    output fetch_pkg::fetch_entry_t         q_wdata,
    output logic                            q_kill,
    output fetch_pkg::addr_t                request_pc,
    input  logic                            is_jal,
    input  logic                            is_branch,
    input  logic                            pred_taken,
    input  fetch_pkg::addr_t                jal_target,
    input  fetch_pkg::addr_t                br_target
);
    import fetch_pkg::*;

    localparam int cnt_w = $clog2(queue_depth) + 1;

    logic outstanding;
    logic discard;

    logic             resp_take;
    logic             resp_use;
    logic             slot_free;
    logic             space_ok;
    logic             fire;
    logic [cnt_w-1:0] pending_writes;
    addr_t            seq_addr;
    addr_t            next_addr;

    // response for the outstanding request
    assign resp_take = outstanding & memresp.valid;
    // discarded ones belong to a stream that was redirected away
    assign resp_use  = resp_take & ~discard;

    assign seq_addr = request_pc + 32'd4;

    // next address in priority order
    always_comb begin
        if (redirect.valid) begin
            next_addr = redirect.addr;
        end else if (resp_use) begin
            if (is_jal) begin
                next_addr = jal_target;
            end else if (is_branch && pred_taken) begin
                next_addr = br_target;
            end else begin
                next_addr = seq_addr;
            end
        end else begin
            // pending address, or the one in flight
            next_addr = request_pc;
        end
    end

    // queue write
    assign q_kill         = redirect.valid;
    assign q_wvalid       = resp_use & ~redirect.valid;
    assign q_wdata.addr   = request_pc;
    assign q_wdata.inst   = memresp.error ? inst_nop : memresp.data;
    assign q_wdata.error  = memresp.error;

    // reserve a slot for every request in flight
    assign pending_writes = {{(cnt_w-1){1'b0}}, q_wvalid};
    assign space_ok       = redirect.valid | (free_slots > pending_writes);
    assign slot_free      = ~outstanding | resp_use;

    assign memreq.valid = slot_free & space_ok;
    assign memreq.addr  = next_addr;

    assign fire = memreq.valid & memreq_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            request_pc  <= reset_pc;
            outstanding <= 1'b0;
            discard     <= 1'b0;
        end else begin
            // holds the in-flight address, else the next one to fetch
            request_pc  <= next_addr;
            outstanding <= fire | (outstanding & ~resp_take);
            if (redirect.valid) begin
                // old request still out there
                discard <= outstanding & ~resp_take;
            end else if (resp_take) begin
                discard <= 1'b0;
            end
        end
    end

endmodule

/* verilog/predecode.sv */
`timescale 1ns/100ps

module predecode (
    input  fetch_pkg::inst_t    inst,
    input  fetch_pkg::addr_t    pc,
    input  logic                error,
    output logic                is_jal,
    output logic                is_branch,
    output fetch_pkg::addr_t    jal_target,
    output fetch_pkg::addr_t    br_target
);
    import fetch_pkg::*;

    inst_word_u word;

    logic [20:0] imm_j;
    logic [12:0] imm_b;
    addr_t       off_j;
    addr_t       off_b;

    assign word.raw = inst;

    // j-type immediate with bit 0 always zero
    assign imm_j = {word.j.imm20,
                    word.j.imm19_12,
                    word.j.imm11,
                    word.j.imm10_1,
                    1'b0};

    // b-type immediate
    assign imm_b = {word.b.imm12,
                    word.b.imm11,
                    word.b.imm10_5,
                    word.b.imm4_1,
                    1'b0};

    assign off_j = {{11{imm_j[20]}}, imm_j};
    assign off_b = {{19{imm_b[12]}}, imm_b};

    assign jal_target = pc + off_j;
    assign br_target  = pc + off_b;

    // a faulted word is just a nop, never a control transfer
    assign is_jal    = ~error & (word.j.opcode == op_jal);
    assign is_branch = ~error & (word.b.opcode == op_branch);

endmodule

/* verilog/branch_predictor.sv */
`timescale 1ns/100ps

module branch_predictor #(
    parameter int index_bits = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::addr_t        pc,
    output logic                    pred_taken,
    input  fetch_pkg::br_update_t   brinfo
);
    import fetch_pkg::*;

    localparam int entries = 2 ** index_bits;

    logic [1:0] counters [entries];

    logic [index_bits-1:0] rd_idx;
    logic [index_bits-1:0] up_idx;
    addr_t                 up_pc;
    logic [1:0]            cur;
    logic [1:0]            nxt;

    // word aligned, so bits 1:0 carry no information
    assign rd_idx = pc[index_bits+1:2];
    assign up_pc  = brinfo.pc;
    assign up_idx = up_pc[index_bits+1:2];

    assign pred_taken = counters[rd_idx][1];

    assign cur = counters[up_idx];

    always_comb begin
        nxt = cur;
        if (brinfo.taken) begin
            if (cur != 2'b11) begin
                nxt = cur + 2'b01;
            end
        end else begin
            if (cur != 2'b00) begin
                nxt = cur - 2'b01;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // weakly not taken
            for (int i = 0; i < entries; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (brinfo.valid) begin
            counters[up_idx] <= nxt;
        end
    end

endmodule

/* verilog/inst_queue.sv */
`timescale 1ns/100ps

module inst_queue #(
    parameter int depth = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      kill,
    input  logic                      wvalid,
    input  fetch_pkg::fetch_entry_t   wdata,
    output logic [$clog2(depth):0]    free_slots,
    output fetch_pkg::fetch_out_t     iresp,
    input  logic                      iresp_ready
);
    import fetch_pkg::*;

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = ptr_w + 1;

    fetch_entry_t mem [depth];

    logic [ptr_w-1:0] rptr;
    logic [ptr_w-1:0] wptr;
    logic [cnt_w-1:0] count;

    logic full;
    logic do_write;
    logic do_read;

    assign full     = (count == cnt_w'(depth));
    // a write racing a kill belongs to the flushed stream
    assign do_write = wvalid & ~kill & ~full;
    assign do_read  = iresp.valid & iresp_ready;

    assign iresp.valid = (count != '0);
    assign iresp.entry = mem[rptr];
    assign free_slots  = cnt_w'(depth) - count;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rptr  <= '0;
            wptr  <= '0;
            count <= '0;
        end else if (kill) begin
            rptr  <= '0;
            wptr  <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wptr <= wptr + 1'b1;
            end
            if (do_read) begin
                rptr <= rptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // addi x0, x0, 0
    localparam inst_t inst_nop = 32'h0000_0013;

    localparam logic [6:0] op_jal    = 7'b110_1111;
    localparam logic [6:0] op_branch = 7'b110_0011;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fields_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fields_t;

    // one fetched word seen as jal or as branch
    typedef union packed {
        inst_t     raw;
        j_fields_t j;
        b_fields_t b;
    } inst_word_u;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        logic  error;
        inst_t data;
    } mem_resp_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } redirect_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
    } br_update_t;

    typedef struct packed {
        addr_t addr;
        inst_t inst;
        logic  error;
    } fetch_entry_t;

    typedef struct packed {
        logic         valid;
        fetch_entry_t entry;
    } fetch_out_t;

endpackage
